// ==== debug_uart_top.f ====
rtl/dbg_pkg.sv
rtl/baud_tick_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/word_assembler.sv
rtl/tx_word_fifo.sv
rtl/debug_unit.sv
rtl/target_core.sv
rtl/debug_uart_top.sv
sim/tb_debug_uart.sv

// ==== rtl/baud_tick_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module baud_tick_gen #(
    parameter int CLKS_PER_TICK = 27
) (
    input  wire  i_clk,
    input  wire  i_rst_n,
    output logic o_tick
);

    localparam int CNT_BITS = (CLKS_PER_TICK > 1) ? $clog2(CLKS_PER_TICK) : 1;
    localparam logic [CNT_BITS-1:0] CNT_MAX = CNT_BITS'(CLKS_PER_TICK - 1);

    logic [CNT_BITS-1:0] cnt;                   // Clocks since last tick

    assign o_tick = (cnt == CNT_MAX);           // One cycle per period

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            cnt <= '0;
        end else if (o_tick) begin
            cnt <= '0;                          // Wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    localparam int WORD_BITS     = 32;          // Commands, replies, registers, instructions
    localparam int BYTE_BITS     = 8;           // UART payload width
    localparam int REG_ADDR_BITS = 3;           // Eight registers

    localparam int CMD_MSB = 31;                // Command code in 31:28
    localparam int CMD_LSB = 28;

    localparam logic [3:0] CMD_LOAD     = 4'd1; // Addr in low bits, data in next word
    localparam logic [3:0] CMD_STEP     = 4'd2; // One instruction, reply PC
    localparam logic [3:0] CMD_RUN      = 4'd3; // Run to halt, reply PC
    localparam logic [3:0] CMD_CLEAR    = 4'd4; // No reply
    localparam logic [3:0] CMD_READ_REG = 4'd5; // Index in 2:0
    localparam logic [3:0] CMD_READ_PC  = 4'd6; // Zero-extended PC

    localparam logic [3:0] OP_ADDI = 4'd1;      // rd = rs + sext(imm)
    localparam logic [3:0] OP_ADD  = 4'd2;      // rd = rd + rs
    localparam logic [3:0] OP_HALT = 4'd15;     // Stop, PC holds

    localparam int OP_MSB  = 31;                // Instruction fields
    localparam int OP_LSB  = 28;
    localparam int RD_MSB  = 26;
    localparam int RD_LSB  = 24;
    localparam int RS_MSB  = 22;
    localparam int RS_LSB  = 20;
    localparam int IMM_MSB = 15;                // Immediate in 15:0

    typedef enum logic [1:0] {
        UART_IDLE,
        UART_START,
        UART_DATA,
        UART_STOP
    } uart_state_t;                             // Shared by receiver and transmitter

endpackage

`default_nettype wire

// ==== rtl/debug_uart_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_uart_top #(
    parameter int CLKS_PER_TICK  = 27,          // 16x oversampling divisor
    parameter int FIFO_ADDR_BITS = 3,           // Eight reply words
    parameter int IMEM_ADDR_BITS = 5
) (
    input  wire i_clk,
    input  wire i_rst_n,
    input  wire i_rx,
    output wire o_tx,
    output wire o_halted
);

    wire                              tick;
    wire                              rx_done;
    wire [dbg_pkg::BYTE_BITS-1:0]     rx_byte;
    wire                              word_valid;
    wire [dbg_pkg::WORD_BITS-1:0]     cmd_word;
    wire                              imem_we;
    wire [IMEM_ADDR_BITS-1:0]         imem_addr;
    wire [dbg_pkg::WORD_BITS-1:0]     imem_data;
    wire                              step;
    wire                              clear;
    wire [dbg_pkg::REG_ADDR_BITS-1:0] reg_sel;
    wire [dbg_pkg::WORD_BITS-1:0]     reg_data;
    wire [IMEM_ADDR_BITS-1:0]         pc;
    wire                              reply_push;
    wire [dbg_pkg::WORD_BITS-1:0]     reply;
    wire                              fifo_empty;  // Low starts a frame
    wire [dbg_pkg::BYTE_BITS-1:0]     tx_byte;
    wire                              tx_done;     // Pops one byte

    baud_tick_gen #(.CLKS_PER_TICK(CLKS_PER_TICK)) u_baud_tick_gen (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .o_tick(tick)
    );

    uart_rx u_uart_rx (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_rx(i_rx), .i_tick(tick),
        .o_done(rx_done), .o_data(rx_byte)
    );

    word_assembler u_word_assembler (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_byte_valid(rx_done), .i_byte(rx_byte),
        .o_word_valid(word_valid), .o_word(cmd_word)
    );

    debug_unit #(.IMEM_ADDR_BITS(IMEM_ADDR_BITS)) u_debug_unit (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_word_valid(word_valid), .i_word(cmd_word),
        .i_reg_data(reg_data), .i_pc(pc), .i_halted(o_halted),
        .o_imem_we(imem_we), .o_imem_addr(imem_addr), .o_imem_data(imem_data),
        .o_step(step), .o_clear(clear), .o_reg_sel(reg_sel),
        .o_reply_push(reply_push), .o_reply(reply)
    );

    target_core #(.IMEM_ADDR_BITS(IMEM_ADDR_BITS)) u_target_core (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_imem_we(imem_we), .i_imem_addr(imem_addr),
        .i_imem_data(imem_data), .i_step(step), .i_clear(clear), .i_reg_sel(reg_sel),
        .o_reg_data(reg_data), .o_pc(pc), .o_halted(o_halted)
    );

    tx_word_fifo #(.FIFO_ADDR_BITS(FIFO_ADDR_BITS)) u_tx_word_fifo (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_push(reply_push), .i_word(reply),
        .i_pop(tx_done), .o_empty(fifo_empty), .o_byte(tx_byte)
    );

    uart_tx u_uart_tx (
        .i_clk(i_clk), .i_rst_n(i_rst_n), .i_start(~fifo_empty), .i_tick(tick),
        .i_data(tx_byte), .o_done(tx_done), .o_tx(o_tx)
    );

endmodule

`default_nettype wire

// ==== rtl/debug_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module debug_unit #(
    parameter int IMEM_ADDR_BITS = 5
) (
    input  wire                               i_clk,
    input  wire                               i_rst_n,
    input  wire                               i_word_valid,
    input  wire  [dbg_pkg::WORD_BITS-1:0]     i_word,
    input  wire  [dbg_pkg::WORD_BITS-1:0]     i_reg_data,
    input  wire  [IMEM_ADDR_BITS-1:0]         i_pc,
    input  wire                               i_halted,
    output logic                              o_imem_we,
    output logic [IMEM_ADDR_BITS-1:0]         o_imem_addr,
    output logic [dbg_pkg::WORD_BITS-1:0]     o_imem_data,
    output logic                              o_step,
    output logic                              o_clear,
    output logic [dbg_pkg::REG_ADDR_BITS-1:0] o_reg_sel,
    output logic                              o_reply_push,
    output logic [dbg_pkg::WORD_BITS-1:0]     o_reply
);

    localparam int PAD_BITS = dbg_pkg::WORD_BITS - IMEM_ADDR_BITS;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_LOAD_DATA,                           // Waiting for instruction word
        ST_RUNNING                              // Stepping the core
    } state_t;

    state_t     state;
    logic       single;                         // STEP leaves RUNNING after one cycle
    logic       reply_reg;                      // Reply carries register, else PC
    logic [3:0] cmd;

    assign cmd     = i_word[dbg_pkg::CMD_MSB:dbg_pkg::CMD_LSB];
    assign o_step  = (state == ST_RUNNING) && !i_halted; // Core never steps once halted
    assign o_reply = reply_reg ? i_reg_data : {{PAD_BITS{1'b0}}, i_pc};

    always_ff @(posedge i_clk) begin
        if (state == ST_IDLE && i_word_valid && cmd == dbg_pkg::CMD_LOAD) begin
            o_imem_addr <= i_word[IMEM_ADDR_BITS-1:0];
        end
        if (state == ST_LOAD_DATA && i_word_valid) begin
            o_imem_data <= i_word;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state        <= ST_IDLE;
            single       <= 1'b0;
            reply_reg    <= 1'b0;
            o_reg_sel    <= '0;
            o_imem_we    <= 1'b0;
            o_clear      <= 1'b0;
            o_reply_push <= 1'b0;
        end else begin
            o_imem_we    <= 1'b0;               // Strobes last one cycle
            o_clear      <= 1'b0;
            o_reply_push <= 1'b0;
            case (state)
                ST_IDLE: begin
                    if (i_word_valid) begin
                        case (cmd)
                            dbg_pkg::CMD_LOAD: state <= ST_LOAD_DATA;
                            dbg_pkg::CMD_STEP: begin
                                state     <= ST_RUNNING;
                                single    <= 1'b1;
                                reply_reg <= 1'b0;
                            end
                            dbg_pkg::CMD_RUN: begin
                                state     <= ST_RUNNING;
                                single    <= 1'b0;
                                reply_reg <= 1'b0;
                            end
                            dbg_pkg::CMD_CLEAR: o_clear <= 1'b1;
                            dbg_pkg::CMD_READ_REG: begin
                                o_reg_sel    <= i_word[dbg_pkg::REG_ADDR_BITS-1:0];
                                reply_reg    <= 1'b1;
                                o_reply_push <= 1'b1; // Register value read back same cycle
                            end
                            dbg_pkg::CMD_READ_PC: begin
                                reply_reg    <= 1'b0;
                                o_reply_push <= 1'b1;
                            end
                            default: state <= ST_IDLE; // Unknown code ignored
                        endcase
                    end
                end
                ST_LOAD_DATA: begin
                    if (i_word_valid) begin
                        o_imem_we <= 1'b1;
                        state     <= ST_IDLE;
                    end
                end
                ST_RUNNING: begin
                    if (single || i_halted) begin // Reply with PC after last step
                        o_reply_push <= 1'b1;
                        state        <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/target_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module target_core #(
    parameter int IMEM_ADDR_BITS = 5
) (
    input  wire                               i_clk,
    input  wire                               i_rst_n,
    input  wire                               i_imem_we,
    input  wire  [IMEM_ADDR_BITS-1:0]         i_imem_addr,
    input  wire  [dbg_pkg::WORD_BITS-1:0]     i_imem_data,
    input  wire                               i_step,
    input  wire                               i_clear,
    input  wire  [dbg_pkg::REG_ADDR_BITS-1:0] i_reg_sel,
    output logic [dbg_pkg::WORD_BITS-1:0]     o_reg_data,
    output logic [IMEM_ADDR_BITS-1:0]         o_pc,
    output logic                              o_halted
);

    localparam int W      = dbg_pkg::WORD_BITS;
    localparam int N_REGS = 1 << dbg_pkg::REG_ADDR_BITS;
    localparam int IMEM_DEPTH = 1 << IMEM_ADDR_BITS;

    logic [W-1:0]                     imem [IMEM_DEPTH];
    logic [W-1:0]                     regs [N_REGS];
    logic [IMEM_ADDR_BITS-1:0]        pc;
    logic                             halted;
    logic [W-1:0]                     inst;     // Instruction at PC
    logic [3:0]                       opcode;
    logic [dbg_pkg::REG_ADDR_BITS-1:0] rd;
    logic [dbg_pkg::REG_ADDR_BITS-1:0] rs;
    logic [W-1:0]                     imm_ext;  // Sign-extended immediate

    assign inst       = imem[pc];
    assign opcode     = inst[dbg_pkg::OP_MSB:dbg_pkg::OP_LSB];
    assign rd         = inst[dbg_pkg::RD_MSB:dbg_pkg::RD_LSB];
    assign rs         = inst[dbg_pkg::RS_MSB:dbg_pkg::RS_LSB];
    assign imm_ext    = {{(W-dbg_pkg::IMM_MSB-1){inst[dbg_pkg::IMM_MSB]}},
                         inst[dbg_pkg::IMM_MSB:0]};
    assign o_reg_data = regs[i_reg_sel];        // Debug read port
    assign o_pc       = pc;
    assign o_halted   = halted;

    always_ff @(posedge i_clk) begin
        if (i_imem_we) begin
            imem[i_imem_addr] <= i_imem_data;   // Loaded by debug unit
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            pc     <= '0;
            halted <= 1'b0;
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_clear) begin             // Debug clear, same as reset
            pc     <= '0;
            halted <= 1'b0;
            for (int i = 0; i < N_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (i_step && !halted) begin
            case (opcode)
                dbg_pkg::OP_ADDI: begin
                    regs[rd] <= regs[rs] + imm_ext;
                    pc       <= pc + 1'b1;
                end
                dbg_pkg::OP_ADD: begin
                    regs[rd] <= regs[rd] + regs[rs];
                    pc       <= pc + 1'b1;
                end
                dbg_pkg::OP_HALT: halted <= 1'b1; // PC stays on HALT
                default: pc <= pc + 1'b1;       // No-op
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/tx_word_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module tx_word_fifo #(
    parameter int FIFO_ADDR_BITS = 3
) (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_push,
    input  wire  [dbg_pkg::WORD_BITS-1:0] i_word,
    input  wire                           i_pop,
    output logic                          o_empty,
    output logic [dbg_pkg::BYTE_BITS-1:0] o_byte
);

    localparam int DEPTH = 1 << FIFO_ADDR_BITS;

    logic [dbg_pkg::WORD_BITS-1:0] mem [DEPTH];
    logic [FIFO_ADDR_BITS:0]       wr_ptr;      // Extra bit tells full from empty
    logic [FIFO_ADDR_BITS:0]       rd_ptr;
    logic [1:0]                    byte_sel;    // Byte of head word on output
    logic                          full;
    logic [dbg_pkg::WORD_BITS-1:0] rd_word;

    assign o_empty = (wr_ptr == rd_ptr);
    assign full    = (wr_ptr[FIFO_ADDR_BITS] != rd_ptr[FIFO_ADDR_BITS]) &&
                     (wr_ptr[FIFO_ADDR_BITS-1:0] == rd_ptr[FIFO_ADDR_BITS-1:0]);
    assign rd_word = mem[rd_ptr[FIFO_ADDR_BITS-1:0]];
    assign o_byte  = rd_word[byte_sel*dbg_pkg::BYTE_BITS +: dbg_pkg::BYTE_BITS]; // LSB first

    always_ff @(posedge i_clk) begin
        if (i_push && !full) begin
            mem[wr_ptr[FIFO_ADDR_BITS-1:0]] <= i_word;
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            byte_sel <= '0;
        end else begin
            if (i_push && !full) begin          // Push to full is dropped
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (i_pop && !o_empty) begin
                byte_sel <= byte_sel + 2'd1;
                if (byte_sel == 2'd3) begin     // Last byte gone, next word
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_rx,
    input  wire                           i_tick,
    output logic                          o_done,
    output logic [dbg_pkg::BYTE_BITS-1:0] o_data
);

    dbg_pkg::uart_state_t state;
    logic                          rx_meta;     // First sync stage
    logic                          rx_sync;     // Safe to sample
    logic [3:0]                    tick_cnt;    // 16 ticks per bit
    logic [2:0]                    bit_cnt;
    logic [dbg_pkg::BYTE_BITS-1:0] shreg;

    assign o_data = shreg;

    always_ff @(posedge i_clk) begin
        if (state == dbg_pkg::UART_DATA && i_tick && tick_cnt == 4'd15) begin
            shreg <= {rx_sync, shreg[dbg_pkg::BYTE_BITS-1:1]}; // LSB first
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            rx_meta  <= 1'b1;                   // Line idles high
            rx_sync  <= 1'b1;
            state    <= dbg_pkg::UART_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            o_done   <= 1'b0;
        end else begin
            rx_meta <= i_rx;
            rx_sync <= rx_meta;
            o_done  <= 1'b0;
            case (state)
                dbg_pkg::UART_IDLE: begin
                    if (!rx_sync) begin         // Falling edge of start bit
                        state    <= dbg_pkg::UART_START;
                        tick_cnt <= '0;
                    end
                end
                dbg_pkg::UART_START: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                        if (tick_cnt == 4'd7) begin // Middle of start bit
                            tick_cnt <= '0;
                            bit_cnt  <= '0;
                            state    <= rx_sync ? dbg_pkg::UART_IDLE : dbg_pkg::UART_DATA;
                        end
                    end
                end
                dbg_pkg::UART_DATA: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 4'd1; // Wraps every bit
                        if (tick_cnt == 4'd15) begin
                            bit_cnt <= bit_cnt + 3'd1;
                            if (bit_cnt == 3'd7) begin
                                state <= dbg_pkg::UART_STOP;
                            end
                        end
                    end
                end
                dbg_pkg::UART_STOP: begin
                    if (i_tick) begin
                        tick_cnt <= tick_cnt + 4'd1;
                        if (tick_cnt == 4'd15) begin // Middle of stop bit
                            o_done <= 1'b1;
                            state  <= dbg_pkg::UART_IDLE;
                        end
                    end
                end
                default: state <= dbg_pkg::UART_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/uart_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_start,
    input  wire                           i_tick,
    input  wire  [dbg_pkg::BYTE_BITS-1:0] i_data,
    output logic                          o_done,
    output logic                          o_tx
);

    dbg_pkg::uart_state_t state;
    logic [3:0]                    tick_cnt;    // 16 ticks per bit
    logic [2:0]                    bit_cnt;
    logic [dbg_pkg::BYTE_BITS-1:0] shreg;       // Bit 0 is on the line

    // Combinational so the FIFO advances before the next idle cycle
    assign o_done = (state == dbg_pkg::UART_STOP) && i_tick && (tick_cnt == 4'd15);
    assign o_tx   = (state == dbg_pkg::UART_START) ? 1'b0 :
                    (state == dbg_pkg::UART_DATA)  ? shreg[0] : 1'b1;

    always_ff @(posedge i_clk) begin
        if (state == dbg_pkg::UART_IDLE && i_start) begin
            shreg <= i_data;                    // Latch byte at start
        end else if (state == dbg_pkg::UART_DATA && i_tick && tick_cnt == 4'd15) begin
            shreg <= shreg >> 1;                // Next bit, LSB first
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state    <= dbg_pkg::UART_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else if (state == dbg_pkg::UART_IDLE) begin
            if (i_start) begin
                state    <= dbg_pkg::UART_START;
                tick_cnt <= '0;
                bit_cnt  <= '0;
            end
        end else if (i_tick) begin
            tick_cnt <= tick_cnt + 4'd1;        // Wraps at bit end
            if (tick_cnt == 4'd15) begin
                case (state)
                    dbg_pkg::UART_START: state <= dbg_pkg::UART_DATA;
                    dbg_pkg::UART_DATA: begin
                        bit_cnt <= bit_cnt + 3'd1;
                        if (bit_cnt == 3'd7) begin
                            state <= dbg_pkg::UART_STOP;
                        end
                    end
                    default: state <= dbg_pkg::UART_IDLE; // End of stop bit
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== rtl/word_assembler.sv ====
`timescale 1ns/1ps
`default_nettype none

module word_assembler (
    input  wire                           i_clk,
    input  wire                           i_rst_n,
    input  wire                           i_byte_valid,
    input  wire  [dbg_pkg::BYTE_BITS-1:0] i_byte,
    output logic                          o_word_valid,
    output logic [dbg_pkg::WORD_BITS-1:0] o_word
);

    logic [1:0] byte_cnt;                       // Bytes held so far

    always_ff @(posedge i_clk) begin
        if (i_byte_valid) begin
            o_word <= {i_byte, o_word[dbg_pkg::WORD_BITS-1:dbg_pkg::BYTE_BITS]}; // In from top
        end
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            byte_cnt     <= '0;
            o_word_valid <= 1'b0;
        end else begin
            o_word_valid <= i_byte_valid && (byte_cnt == 2'd3); // Fourth byte
            if (i_byte_valid) begin
                byte_cnt <= byte_cnt + 2'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f debug_uart_top.f \
    --top-module tb_debug_uart \
    -o Vtb_debug_uart

./obj_dir/Vtb_debug_uart > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    echo "Simulation failed"
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
echo "Simulation passed"

// ==== sim/tb_debug_uart.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_debug_uart;

    localparam int      CLK_NS    = 10;
    localparam int      BIT_CLKS  = 32;                 // 16 ticks of 2 clocks each
    localparam int      HALF_BIT  = BIT_CLKS / 2;
    localparam int      MAX_ROWS  = 128;
    localparam int      ROW_BITS  = 84;                 // Command, reply and idle gap
    localparam longint  MARGIN_NS = 400 * BIT_CLKS * CLK_NS;
    localparam [31:0]   SEED      = 32'h98aa9e13;

    logic        clk;
    logic        rst_n;
    logic        rx;                                    // Host to DUT line
    wire         tx;
    wire         halted;

    logic [31:0] row_cmd    [MAX_ROWS];                 // Stimulus table
    bit          row_reply  [MAX_ROWS];
    logic [31:0] row_exp    [MAX_ROWS];
    bit          row_halted [MAX_ROWS];
    int          n_rows;
    bit          table_ready;

    logic [31:0] reply_words [MAX_ROWS];                // Words seen on o_tx
    int          rx_count;

    logic [31:0] model_imem [32];                       // Reference model state
    logic [31:0] model_regs [8];
    logic [4:0]  model_pc;
    bit          model_halted;
    logic [31:0] rng;

    debug_uart_top #(.CLKS_PER_TICK(2)) DUT (
        .i_clk(clk), .i_rst_n(rst_n), .i_rx(rx), .o_tx(tx), .o_halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %s got %08h expected %08h", name, got, exp));
        end
    endtask

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] enc_addi(input logic [2:0] rd, input logic [2:0] rs,
                                             input logic [15:0] imm);
        return {dbg_pkg::OP_ADDI, 1'b0, rd, 1'b0, rs, 4'b0, imm};
    endfunction

    function automatic logic [31:0] enc_add(input logic [2:0] rd, input logic [2:0] rs);
        return {dbg_pkg::OP_ADD, 1'b0, rd, 1'b0, rs, 20'b0};
    endfunction

    // One instruction of the reference core; no effect once halted
    task automatic model_step();
        logic [31:0] inst;
        logic [3:0]  op;
        logic [2:0]  rd;
        logic [2:0]  rs;
        logic [31:0] imm;
        inst = model_imem[model_pc];
        op   = inst[31:28];
        rd   = inst[26:24];
        rs   = inst[22:20];
        imm  = {{16{inst[15]}}, inst[15:0]};                // Sign extension
        if (!model_halted) begin
            if (op == dbg_pkg::OP_ADDI) begin
                model_regs[rd] = model_regs[rs] + imm;
                model_pc       = model_pc + 5'd1;
            end else if (op == dbg_pkg::OP_ADD) begin
                model_regs[rd] = model_regs[rd] + model_regs[rs];
                model_pc       = model_pc + 5'd1;
            end else if (op == dbg_pkg::OP_HALT) begin
                model_halted = 1'b1;                        // PC stays on HALT
            end else begin
                model_pc = model_pc + 5'd1;
            end
        end
    endtask

    task automatic reset_model();
        model_pc     = '0;
        model_halted = 1'b0;
        for (int i = 0; i < 8; i++) begin
            model_regs[i] = '0;
        end
    endtask

    task automatic add_row(input logic [31:0] cmd, input bit has_reply,
                           input logic [31:0] exp);
        row_cmd[n_rows]    = cmd;
        row_reply[n_rows]  = has_reply;
        row_exp[n_rows]    = exp;
        row_halted[n_rows] = model_halted;                  // Level after the row
        n_rows++;
    endtask

    task automatic load_instruction(input logic [4:0] addr, input logic [31:0] inst);
        model_imem[addr] = inst;
        add_row({dbg_pkg::CMD_LOAD, 23'b0, addr}, 1'b0, 32'h0);
        add_row(inst, 1'b0, 32'h0);                         // Data word follows
    endtask

    task automatic step_once();
        model_step();
        add_row({dbg_pkg::CMD_STEP, 28'b0}, 1'b1, {27'b0, model_pc});
    endtask

    task automatic run_to_halt();
        for (int n = 0; n < 64 && !model_halted; n++) begin
            model_step();
        end
        add_row({dbg_pkg::CMD_RUN, 28'b0}, 1'b1, {27'b0, model_pc});
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < 8; i++) begin
            add_row({dbg_pkg::CMD_READ_REG, 25'b0, 3'(i)}, 1'b1, model_regs[i]);
        end
    endtask

    task automatic clear_core();
        reset_model();
        add_row({dbg_pkg::CMD_CLEAR, 28'b0}, 1'b0, 32'h0);
    endtask

    // Random ADDI or ADD; the first ones are forced to ADDI so registers get values
    task automatic pick_random_inst(input logic [4:0] addr, input bit force_addi);
        rng = xorshift32(rng);
        if (force_addi || rng[31]) begin
            load_instruction(addr, enc_addi(rng[26:24], rng[22:20], rng[15:0]));
        end else begin
            load_instruction(addr, enc_add(rng[26:24], rng[22:20]));
        end
    endtask

    task automatic build_table();
        n_rows = 0;
        reset_model();                                      // Model matches reset state
        add_row({4'hE, 28'h0}, 1'b0, 32'h0);                // Unknown code gets no reply
        for (int a = 0; a < 6; a++) begin
            pick_random_inst(5'(a), a < 2);
        end
        for (int s = 0; s < 6; s++) begin
            step_once();
        end
        read_all_regs();
        for (int a = 6; a < 11; a++) begin
            pick_random_inst(5'(a), 1'b0);
        end
        load_instruction(5'd11, {dbg_pkg::OP_HALT, 28'b0});
        run_to_halt();
        read_all_regs();
        step_once();                                        // PC holds while halted
        step_once();
        clear_core();
        add_row({dbg_pkg::CMD_READ_PC, 28'b0}, 1'b1, {27'b0, model_pc});
        read_all_regs();
    endtask

    // 8N1 frames, LSB of the word first, held BIT_CLKS clocks per bit
    task automatic send_word(input logic [31:0] w);
        logic [9:0] frame;
        for (int k = 0; k < 4; k++) begin
            frame = {1'b1, w[k*8 +: 8], 1'b0};              // Stop, data, start
            for (int b = 0; b < 10; b++) begin
                @(posedge clk);
                rx <= frame[b];
                repeat (BIT_CLKS - 1) @(posedge clk);
            end
        end
    endtask

    initial begin : reply_receiver
        logic [7:0]  rx_byte;
        logic [31:0] word;
        int          nbytes;
        nbytes = 0;
        word   = '0;
        @(posedge rst_n);
        forever begin
            @(negedge clk);
            if (tx === 1'b0) begin                          // Start edge seen
                repeat (HALF_BIT) @(negedge clk);
                if (tx !== 1'b0) begin
                    abort_run("Reply frame error: start bit was not low at mid-bit");
                end
                for (int b = 0; b < 8; b++) begin
                    repeat (BIT_CLKS) @(negedge clk);
                    rx_byte[b] = tx;
                end
                repeat (BIT_CLKS) @(negedge clk);
                if (tx !== 1'b1) begin
                    abort_run("Reply frame error: stop bit was not high at mid-bit");
                end
                word = {rx_byte, word[31:8]};               // First byte ends up lowest
                nbytes++;
                if (nbytes == 4) begin
                    if (rx_count >= MAX_ROWS) begin
                        abort_run("More reply words arrived than the table can hold");
                    end
                    reply_words[rx_count] = word;
                    rx_count++;
                    nbytes = 0;
                end
            end
        end
    end

    initial begin : watchdog
        longint limit_ns;
        wait (table_ready);
        limit_ns = longint'(n_rows) * ROW_BITS * BIT_CLKS * CLK_NS + MARGIN_NS;
        #(limit_ns);
        abort_run($sformatf("Timeout: the command table did not finish within %0d ns",
                            limit_ns));
    end

    initial begin : main_seq
        int replies_seen;
        rx           = 1'b1;                                // Line idles high
        rst_n        = 1'b0;
        rng          = SEED;
        rx_count     = 0;
        table_ready  = 1'b0;
        replies_seen = 0;
        build_table();
        table_ready = 1'b1;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4 * BIT_CLKS) begin                         // Quiet before any command
            @(negedge clk);
            check_value("o_tx", tx, 32'h1);
            check_value("o_halted", halted, 32'h0);
        end
        check_value("reply count", rx_count, 32'h0);
        for (int r = 0; r < n_rows; r++) begin
            send_word(row_cmd[r]);
            if (row_reply[r]) begin
                while (rx_count == replies_seen) @(negedge clk);
                check_value($sformatf("reply[%0d]", r), reply_words[replies_seen], row_exp[r]);
                replies_seen++;
            end else begin
                repeat (2 * BIT_CLKS) @(negedge clk);       // Let the command take effect
            end
            @(negedge clk);
            check_value($sformatf("o_halted[%0d]", r), halted, row_halted[r]);
        end
        repeat (80 * BIT_CLKS) @(negedge clk);              // Catch any stray reply
        check_value("reply count", rx_count, replies_seen);
        $display("TEST OK");
        $finish;
    end

endmodule

`default_nettype wire
